/* hw/hps_cfg_pkg.sv */
// Shared widths, reset defaults and enum types for the host configuration path
// Covers the command decoder, the register stage and the window stage

package hps_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	// Host data word
	localparam int IO_W  = 16;
	// Pixel or line dimension
	localparam int DIM_W = 12;
	// Running index of data words after a command
	localparam int CNT_W = 8;
	localparam int VOL_W = 5;
	localparam int LED_W = 8;
	// Product of two dimensions, before the divide
	localparam int MUL_W = 2 * DIM_W;

	////////////////////////////////////////////////////////////////////////////
	// Reset defaults, 1920x1080 active area

	localparam logic [DIM_W-1:0] DEF_WIDTH  = DIM_W'(1920);
	localparam logic [DIM_W-1:0] DEF_HEIGHT = DIM_W'(1080);

	////////////////////////////////////////////////////////////////////////////
	// Types

	// Kept opcodes, anything else folds into CMD_OTHER
	typedef enum logic [7:0] {
		CMD_TIMING = 8'h20,
		CMD_LED    = 8'h25,
		CMD_VOL    = 8'h26,
		CMD_VSET   = 8'h27,
		CMD_HSET   = 8'h37,
		CMD_ARC    = 8'h3A,
		CMD_OTHER  = 8'hFF
	} cmd_e;

	typedef enum logic {
		WAIT_CMD = 1'b0,
		HAVE_CMD = 1'b1
	} dec_state_e;

	// Window sequencer, calc at 0, clamp at 6, output at 7
	typedef enum logic [2:0] {
		STEP_CALC, STEP_W1, STEP_W2, STEP_W3,
		STEP_W4, STEP_W5, STEP_CLAMP, STEP_OUT
	} win_step_e;

endpackage

/* hw/cfg_wr_if.sv */
// Decoded command writes, decoder to register stage

`timescale 1ns/1ps

interface cfg_wr_if;
	import hps_cfg_pkg::*;

	// One-cycle pulse per data word
	logic             wr;
	cmd_e             cmd;
	logic [CNT_W-1:0] idx;
	logic [IO_W-1:0]  data;

	modport dec (
		output wr,
		output cmd,
		output idx,
		output data
	);

	modport regs (
		input wr,
		input cmd,
		input idx,
		input data
	);

endinterface

/* hw/video_par_if.sv */
// Video size settings, register stage to window stage

`timescale 1ns/1ps

interface video_par_if;
	import hps_cfg_pkg::*;

	logic [DIM_W-1:0] width;
	logic [DIM_W-1:0] height;
	// Size limits, zero means no limit
	logic [DIM_W-1:0] vset;
	logic [DIM_W-1:0] hset;
	logic             freescale;
	// Two custom aspect-ratio pairs
	logic [DIM_W-1:0] arc1x;
	logic [DIM_W-1:0] arc1y;
	logic [DIM_W-1:0] arc2x;
	logic [DIM_W-1:0] arc2y;

	modport src (output width, height, vset, hset, freescale, arc1x, arc1y, arc2x, arc2y);

	modport dst (input width, height, vset, hset, freescale, arc1x, arc1y, arc2x, arc2y);

endinterface

/* hw/cmd_decode.sv */
// Host bus decoder: strobe edge detect, acknowledge, command and index tracking

`timescale 1ns/1ps

module cmd_decode (
	input  logic                         clk_sys,
	input  logic                         resetd,
	input  logic                         i_io_uio,
	input  logic                         i_io_clk,
	input  logic [hps_cfg_pkg::IO_W-1:0] i_io_din,
	output logic                         o_io_ack,
	cfg_wr_if.dec                        wr
);
	import hps_cfg_pkg::*;

	logic             clk_d1;
	logic             strobe;
	dec_state_e       state;
	logic [CNT_W-1:0] cnt;

	// Map the low byte of a command word onto the kept opcodes
	function automatic cmd_e to_cmd(input logic [7:0] op);
		cmd_e c;
		case (op)
			8'h20:   c = CMD_TIMING;
			8'h25:   c = CMD_LED;
			8'h26:   c = CMD_VOL;
			8'h27:   c = CMD_VSET;
			8'h37:   c = CMD_HSET;
			8'h3A:   c = CMD_ARC;
			default: c = CMD_OTHER;
		endcase
		return c;
	endfunction

	// First cycle of a high strobe level
	assign strobe = i_io_clk & ~clk_d1;

	////////////////////////////////////////////////////////////////////////////
	// Acknowledge is the strobe level two cycles late

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_d1   <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			clk_d1   <= i_io_clk;
			o_io_ack <= clk_d1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command and data words

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state  <= WAIT_CMD;
			cnt    <= '0;
			wr.wr  <= 1'b0;
		end else begin
			wr.wr <= 1'b0;
			if (!i_io_uio) begin
				state <= WAIT_CMD;
			end else if (strobe) begin
				if (state == WAIT_CMD) begin
					state  <= HAVE_CMD;
					wr.cmd <= to_cmd(i_io_din[7:0]);
					cnt    <= '0;
				end else begin
					wr.wr   <= 1'b1;
					wr.idx  <= cnt;
					wr.data <= i_io_din;
					cnt     <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* hw/cfg_regs.sv */
// Configuration registers written by decoded host commands
// Also drives the LED overtake mux and the volume attenuation

`timescale 1ns/1ps

module cfg_regs (
	input  logic                          clk_sys,
	input  logic                          resetd,
	cfg_wr_if.regs                        wr,
	input  logic [hps_cfg_pkg::LED_W-1:0] i_led_status,
	output logic [hps_cfg_pkg::LED_W-1:0] o_led,
	output logic [hps_cfg_pkg::VOL_W-1:0] o_vol_att,
	video_par_if.src                      par
);
	import hps_cfg_pkg::*;

	logic [LED_W-1:0] led_mask;
	logic [LED_W-1:0] led_state;
	logic [DIM_W-1:0] din_dim;

	// Dimensions always come from the low bits of the word
	assign din_dim = wr.data[DIM_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Command execution

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			par.width     <= DEF_WIDTH;
			par.height    <= DEF_HEIGHT;
			par.vset      <= '0;
			par.hset      <= '0;
			par.freescale <= 1'b0;
			par.arc1x     <= '0;
			par.arc1y     <= '0;
			par.arc2x     <= '0;
			par.arc2y     <= '0;
			led_mask      <= '0;
			led_state     <= '0;
			o_vol_att     <= '0;
		end else if (wr.wr) begin
			case (wr.cmd)
				// Only active width and height, porch and sync words dropped
				CMD_TIMING: begin
					if (wr.idx == CNT_W'(0))
						par.width <= din_dim;
					if (wr.idx == CNT_W'(4))
						par.height <= din_dim;
				end

				CMD_LED: begin
					led_mask  <= wr.data[2*LED_W-1:LED_W];
					led_state <= wr.data[LED_W-1:0];
				end

				CMD_VOL:
					o_vol_att <= wr.data[VOL_W-1:0];

				CMD_VSET:
					par.vset <= din_dim;

				CMD_HSET: begin
					par.freescale <= wr.data[IO_W-1];
					par.hset      <= din_dim;
				end

				CMD_ARC: begin
					case (wr.idx)
						CNT_W'(0): par.arc1x <= din_dim;
						CNT_W'(1): par.arc1y <= din_dim;
						CNT_W'(2): par.arc2x <= din_dim;
						CNT_W'(3): par.arc2y <= din_dim;
						default: ;
					endcase
				end

				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// LED overtake

	// Host state where masked, board status elsewhere
	assign o_led = (led_mask & led_state) | (~led_mask & i_led_status);

endmodule

/* hw/video_window.sv */
// Picture window centring for the requested aspect ratio
// Eight-step sequencer, recalculates continuously

`timescale 1ns/1ps

module video_window (
	input  logic                          clk_sys,
	input  logic                          resetd,
	video_par_if.dst                      par,
	input  logic [hps_cfg_pkg::DIM_W-1:0] i_ar_x,
	input  logic [hps_cfg_pkg::DIM_W-1:0] i_ar_y,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_hmin,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_hmax,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_vmin,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_vmax
);
	import hps_cfg_pkg::*;

	win_step_e        step;
	// Effective (limited) size
	logic [DIM_W-1:0] eff_w;
	logic [DIM_W-1:0] eff_h;
	// Selected ratio
	logic [DIM_W-1:0] arx;
	logic [DIM_W-1:0] ary;
	logic [MUL_W-1:0] wcalc;
	logic [MUL_W-1:0] hcalc;
	logic [DIM_W-1:0] videow;
	logic [DIM_W-1:0] videoh;
	logic [DIM_W-1:0] h_off;
	logic [DIM_W-1:0] v_off;

	////////////////////////////////////////////////////////////////////////////
	// Limits and ratio selection, every cycle

	always_ff @(posedge clk_sys) begin
		eff_h <= (par.vset != '0 && par.vset < par.height) ? par.vset : par.height;
		eff_w <= (par.hset != '0 && par.hset < par.width) ? par.hset : par.width;

		// Zero y selects a custom pair by number
		if (i_ar_y == '0) begin
			if (i_ar_x == DIM_W'(1)) begin
				arx <= par.arc1x;
				ary <= par.arc1y;
			end else if (i_ar_x == DIM_W'(2)) begin
				arx <= par.arc2x;
				ary <= par.arc2y;
			end else begin
				arx <= '0;
				ary <= '0;
			end
		end else begin
			arx <= i_ar_x;
			ary <= i_ar_y;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer

	// Offsets centre the clamped picture in the full active area
	assign h_off = (par.width - videow) >> 1;
	assign v_off = (par.height - videoh) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			step <= STEP_CALC;
		else
			step <= win_step_e'(step + 3'd1);
	end

	// Candidate size, then clamp; divides have several steps to settle
	always_ff @(posedge clk_sys) begin
		case (step)
			STEP_CALC: begin
				if (par.freescale || arx == '0 || ary == '0) begin
					wcalc <= MUL_W'(eff_w);
					hcalc <= MUL_W'(eff_h);
				end else begin
					wcalc <= (MUL_W'(eff_h) * MUL_W'(arx)) / MUL_W'(ary);
					hcalc <= (MUL_W'(eff_w) * MUL_W'(ary)) / MUL_W'(arx);
				end
			end
			STEP_CLAMP: begin
				videow <= (wcalc > MUL_W'(eff_w)) ? eff_w : wcalc[DIM_W-1:0];
				videoh <= (hcalc > MUL_W'(eff_h)) ? eff_h : hcalc[DIM_W-1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else if (step == STEP_OUT) begin
			o_hmin <= h_off;
			o_hmax <= h_off + videow - 1'b1;
			o_vmin <= v_off;
			o_vmax <= v_off + videoh - 1'b1;
		end
	end

endmodule

/* hw/hps_cfg_top.sv */
// Top level of the host configuration path
// Decoder, register stage and window stage joined by two interfaces

`timescale 1ns/1ps

module hps_cfg_top (
	input  logic                          clk_sys,
	input  logic                          resetd,
	// Host bus
	input  logic                          i_io_uio,
	input  logic                          i_io_clk,
	input  logic [hps_cfg_pkg::IO_W-1:0]  i_io_din,
	output logic                          o_io_ack,
	// LEDs and audio
	input  logic [hps_cfg_pkg::LED_W-1:0] i_led_status,
	output logic [hps_cfg_pkg::LED_W-1:0] o_led,
	output logic [hps_cfg_pkg::VOL_W-1:0] o_vol_att,
	// Aspect ratio request and window result
	input  logic [hps_cfg_pkg::DIM_W-1:0] i_ar_x,
	input  logic [hps_cfg_pkg::DIM_W-1:0] i_ar_y,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_hmin,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_hmax,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_vmin,
	output logic [hps_cfg_pkg::DIM_W-1:0] o_vmax
);

	cfg_wr_if    u_wr_if ();
	video_par_if u_par_if ();

	cmd_decode u_decode (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_uio (i_io_uio),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.wr       (u_wr_if.dec)
	);

	cfg_regs u_regs (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.wr           (u_wr_if.regs),
		.i_led_status (i_led_status),
		.o_led        (o_led),
		.o_vol_att    (o_vol_att),
		.par          (u_par_if.src)
	);

	video_window u_window (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.par     (u_par_if.dst),
		.i_ar_x  (i_ar_x),
		.i_ar_y  (i_ar_y),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

endmodule

/* bench/tb_clkgen.sv */
// Testbench clock with a 4 ns period, reset held for the first 4 cycles

`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Release just after an edge, like the other stimulus
	initial begin
		resetd = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1 resetd = 1'b0;
	end

endmodule

/* bench/hps_cfg_chk.sv */
// Concurrent assertions on the host bus handshake and the window order
// Bound to the top level

`timescale 1ns/1ps

module hps_cfg_chk (
	input logic                          clk_sys,
	input logic                          resetd,
	input logic                          i_io_clk,
	input logic                          o_io_ack,
	input logic                          i_wr,
	input logic [hps_cfg_pkg::DIM_W-1:0] o_hmin,
	input logic [hps_cfg_pkg::DIM_W-1:0] o_hmax
);

	logic [3:0] run_cnt;
	logic       win_valid;

	// Window valid once a full sequencer pass has run
	always_ff @(posedge clk_sys) begin
		if (resetd)
			run_cnt <= '0;
		else if (run_cnt != 4'hF)
			run_cnt <= run_cnt + 4'h1;
	end

	assign win_valid = (run_cnt == 4'hF);

	ack_delay: assert property (@(posedge clk_sys) disable iff (resetd)
		o_io_ack == $past(i_io_clk, 2))
		else $error("acknowledge is not the strobe level two cycles late");

	wr_pulse: assert property (@(posedge clk_sys) disable iff (resetd)
		i_wr |=> !i_wr)
		else $error("decoded write lasts longer than one cycle");

	win_order: assert property (@(posedge clk_sys) disable iff (resetd)
		win_valid |-> o_hmin <= o_hmax)
		else $error("window hmin is above hmax");

endmodule

bind hps_cfg_top hps_cfg_chk u_chk (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_io_clk (i_io_clk),
	.o_io_ack (o_io_ack),
	.i_wr     (u_wr_if.wr),
	.o_hmin   (o_hmin),
	.o_hmax   (o_hmax)
);

/* bench/hps_cfg_tb.sv */
// Testbench for the host configuration path
// Host bus stimulus, register model, window reference and output comparison

`timescale 1ns/1ps

module hps_cfg_tb;
	import hps_cfg_pkg::*;

	// Tests take about 2500 cycles and the limit leaves a wide margin
	localparam int CYCLE_LIMIT = 20000;

	logic             clk_sys;
	logic             resetd;
	logic             i_io_uio;
	logic             i_io_clk;
	logic [IO_W-1:0]  i_io_din;
	logic [LED_W-1:0] i_led_status;
	logic [DIM_W-1:0] i_ar_x;
	logic [DIM_W-1:0] i_ar_y;
	logic             o_io_ack;
	logic [LED_W-1:0] o_led;
	logic [VOL_W-1:0] o_vol_att;
	logic [DIM_W-1:0] o_hmin;
	logic [DIM_W-1:0] o_hmax;
	logic [DIM_W-1:0] o_vmin;
	logic [DIM_W-1:0] o_vmax;

	// Register model
	int               m_width;
	int               m_height;
	int               m_vset;
	int               m_hset;
	int               m_free;
	int               m_vol;
	int               m_arc [4];
	logic [LED_W-1:0] m_mask;
	logic [LED_W-1:0] m_state;

	logic [31:0]      rng;
	logic [IO_W-1:0]  tx_q [$];
	int               change_cnt;
	int               done_cnt;
	int               cycle_cnt;
	// Strobe history for the acknowledge check
	logic             clk_d1;
	logic             clk_d2;

	tb_clkgen u_clkgen (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	hps_cfg_top u_dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and reference

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int rand_below(input int n);
		rng = xorshift32(rng);
		return int'(rng % 32'(n));
	endfunction

	// Expected LEDs take the host state where the mask bit is set
	function automatic logic [LED_W-1:0] ref_led(input logic [LED_W-1:0] status);
		logic [LED_W-1:0] led;
		for (int b = 0; b < LED_W; b++)
			led[b] = m_mask[b] ? m_state[b] : status[b];
		return led;
	endfunction

	// Expected window as {hmin, hmax, vmin, vmax}
	function automatic logic [4*DIM_W-1:0] ref_window(input int ar_x, input int ar_y);
		int eff_w;
		int eff_h;
		int rx;
		int ry;
		int cw;
		int ch;
		int hmin;
		int vmin;
		eff_w = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		eff_h = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		rx = ar_x;
		ry = ar_y;
		if (ar_y == 0) begin
			rx = (ar_x == 1) ? m_arc[0] : (ar_x == 2) ? m_arc[2] : 0;
			ry = (ar_x == 1) ? m_arc[1] : (ar_x == 2) ? m_arc[3] : 0;
		end
		if (m_free != 0 || rx == 0 || ry == 0) begin
			cw = eff_w;
			ch = eff_h;
		end else begin
			cw = (eff_h * rx) / ry;
			ch = (eff_w * ry) / rx;
		end
		if (cw > eff_w)
			cw = eff_w;
		if (ch > eff_h)
			ch = eff_h;
		hmin = (m_width - cw) / 2;
		vmin = (m_height - ch) / 2;
		return {DIM_W'(hmin), DIM_W'(hmin + cw - 1), DIM_W'(vmin), DIM_W'(vmin + ch - 1)};
	endfunction

	task automatic check_val(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch on %s", what);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host bus

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// Strobe high for 4 cycles and then low for 4
	task automatic host_word(input logic [IO_W-1:0] w);
		i_io_din = w;
		i_io_clk = 1'b1;
		repeat (4) tick();
		i_io_clk = 1'b0;
		repeat (4) tick();
	endtask

	// Command word, the queued data words, then deselect
	task automatic host_cmd(input logic [7:0] op);
		i_io_uio = 1'b1;
		tick();
		host_word({8'h00, op});
		while (tx_q.size() > 0)
			host_word(tx_q.pop_front());
		i_io_uio = 1'b0;
		repeat (2) tick();
	endtask

	// Hand a change to the compare process and wait for its verdict
	task automatic settle();
		change_cnt++;
		wait (done_cnt == change_cnt);
		tick();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checkers

	initial begin : compare
		logic [4*DIM_W-1:0] win;
		forever begin
			wait (change_cnt != done_cnt);
			repeat (20) @(posedge clk_sys);
			@(negedge clk_sys);
			win = ref_window(int'(i_ar_x), int'(i_ar_y));
			check_val("o_led", int'(o_led), int'(ref_led(i_led_status)));
			check_val("o_vol_att", int'(o_vol_att), m_vol);
			check_val("o_hmin", int'(o_hmin), int'(win[3*DIM_W +: DIM_W]));
			check_val("o_hmax", int'(o_hmax), int'(win[2*DIM_W +: DIM_W]));
			check_val("o_vmin", int'(o_vmin), int'(win[DIM_W +: DIM_W]));
			check_val("o_vmax", int'(o_vmax), int'(win[0 +: DIM_W]));
			done_cnt = change_cnt;
		end
	end

	// Ack seen at a falling edge is the strobe from two falling edges back
	always @(negedge clk_sys) begin
		check_val("o_io_ack", int'(o_io_ack), int'(clk_d2));
		clk_d2 = clk_d1;
		clk_d1 = i_io_clk;
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		logic [IO_W-1:0] w;
		int              i;
		rng = 32'hb1b3ce8b;
		i_io_uio = 1'b0;
		i_io_clk = 1'b0;
		i_io_din = '0;
		i_led_status = '0;
		i_ar_x = '0;
		i_ar_y = '0;
		m_width = 1920;
		m_height = 1080;
		m_vset = 0;
		m_hset = 0;
		m_free = 0;
		m_vol = 0;
		m_arc = '{0, 0, 0, 0};
		m_mask = '0;
		m_state = '0;
		change_cnt = 0;
		done_cnt = 0;
		cycle_cnt = 0;
		clk_d1 = 1'b0;
		clk_d2 = 1'b0;
		@(negedge resetd);
		tick();

		// Defaults with a zero ratio
		for (i = 0; i < 4; i++) begin
			i_led_status = LED_W'(rand_below(256));
			settle();
		end
		check_val("default hmax", int'(o_hmax), 1919);
		check_val("default vmax", int'(o_vmax), 1079);

		// LED overtake and volume
		for (i = 0; i < 8; i++) begin
			w = IO_W'(rand_below(65536));
			tx_q.push_back(w);
			host_cmd(CMD_LED);
			m_mask = w[15:8];
			m_state = w[7:0];
			i_led_status = LED_W'(rand_below(256));
			settle();
			w = IO_W'(rand_below(65536));
			tx_q.push_back(w);
			host_cmd(CMD_VOL);
			m_vol = int'(w[VOL_W-1:0]);
			settle();
		end

		// Timing words 0 and 4 carry the size and the rest is noise
		for (i = 0; i < 6; i++) begin
			m_width = 640 + rand_below(1408);
			m_height = 480 + rand_below(1024);
			for (int k = 0; k < 8; k++) begin
				w = IO_W'(rand_below(65536));
				if (k == 0)
					w[DIM_W-1:0] = DIM_W'(m_width);
				if (k == 4)
					w[DIM_W-1:0] = DIM_W'(m_height);
				tx_q.push_back(w);
			end
			host_cmd(CMD_TIMING);
			i_ar_x = DIM_W'(1 + rand_below(16));
			i_ar_y = DIM_W'(1 + rand_below(16));
			settle();
		end

		// Custom pairs picked by number where 3 gives no ratio
		for (i = 0; i < 4; i++) begin
			for (int k = 0; k < 4; k++) begin
				m_arc[k] = 1 + rand_below(16);
				tx_q.push_back(IO_W'(m_arc[k]));
			end
			host_cmd(CMD_ARC);
			i_ar_y = '0;
			i_ar_x = DIM_W'(1 + i % 3);
			settle();
		end

		// Size limits below and above the active size
		i_ar_x = DIM_W'(16);
		i_ar_y = DIM_W'(9);
		for (i = 0; i < 4; i++) begin
			m_vset = (i % 2 == 0) ? 256 + rand_below(m_height - 256)
				: m_height + 1 + rand_below(256);
			tx_q.push_back(IO_W'(m_vset));
			host_cmd(CMD_VSET);
			m_hset = (i < 2) ? 256 + rand_below(m_width - 256)
				: m_width + 1 + rand_below(256);
			tx_q.push_back(IO_W'(m_hset));
			host_cmd(CMD_HSET);
			settle();
		end

		// Freescale fills the effective size
		for (i = 0; i < 2; i++) begin
			m_free = 1;
			m_hset = 256 + rand_below(m_width - 256);
			tx_q.push_back({1'b1, 3'b000, DIM_W'(m_hset)});
			host_cmd(CMD_HSET);
			settle();
		end

		// Deselect after a command word so the next word is a command again
		i_io_uio = 1'b1;
		tick();
		host_word({8'h00, CMD_VOL});
		i_io_uio = 1'b0;
		repeat (2) tick();
		tx_q.push_back(IO_W'(rand_below(65536)));
		host_cmd(8'((m_vol + 1) % 32));
		settle();

		// Data under an unknown opcode is dropped
		for (int k = 0; k < 4; k++)
			tx_q.push_back(IO_W'(rand_below(65536)));
		host_cmd(8'h55);
		settle();

		$display("Test OK");
		$finish;
	end

endmodule

/* build.f */
hw/hps_cfg_pkg.sv
hw/cfg_wr_if.sv
hw/video_par_if.sv
hw/cmd_decode.sv
hw/cfg_regs.sv
hw/video_window.sv
hw/hps_cfg_top.sv
bench/tb_clkgen.sv
bench/hps_cfg_chk.sv
bench/hps_cfg_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = hps_cfg_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
